//--- Bender.yml
package:
  name: jtag_port

sources:
  - jtagPkg.sv
  - tckSampler.sv
  - tapDecode.sv
  - cmdExecute.sv
  - tdoResult.sv
  - jtagPort.sv
  - target: test
    files:
      - portChecker.sv
      - tb_jtagPort.sv

//--- all.f
jtagPkg.sv
tckSampler.sv
tapDecode.sv
cmdExecute.sv
tdoResult.sv
jtagPort.sv
portChecker.sv
tb_jtagPort.sv

//--- cmdExecute.sv
`timescale 1ns/1ps

module cmdExecute #(
	parameter int DATA_W = 16 // Data and address width.
) (
	input  logic                       i_clk,
	input  logic                       i_rstN,
	input  jtagPkg::tapState_e         i_state,
	input  logic [jtagPkg::CMD_W-1:0]  i_cmd,
	input  logic                       i_shiftBit,  // TDI during DSHFT.
	input  logic                       i_shiftEn,   // Shift strobe during DSHFT.
	input  logic                       i_isBooted,  // Gates pause and resume.
	input  logic                       i_isPaused,  // Gates memory and access commands.
	input  logic [DATA_W-1:0]          i_memDataIn,
	output logic [DATA_W-1:0]          o_memAddr,
	output logic [DATA_W-1:0]          o_memDataOut,
	output logic                       o_memWr,     // Valid with o_memEn.
	output logic                       o_memEn,     // One-cycle access strobe.
	output logic                       o_doPause,
	output logic                       o_dataMsb,   // For TDO.
	output logic                       o_spiSel,
	output logic                       o_scanSel
);

	jtagPkg::jtagOp_e    op;
	logic                cmdValid;    // Upper command bits all zero.
	logic                inUpdate;
	logic                updDoneQ;    // Set while UPDATE persists.
	logic                firstUpdate; // First cycle of an UPDATE.
	logic                isAddr, isMem, isAccess, isState;
	logic                exeAddr, exeMem, exeAccess, exeState;
	logic [DATA_W-1:0]   dataQ;
	logic [DATA_W-1:0]   addrQ;
	logic                spiSelQ, scanSelQ;
	logic                pauseQ;

	// ------------------------------
	// Command decode
	// ------------------------------

	assign op       = jtagPkg::jtagOp_e'(i_cmd[jtagPkg::OP_W-1:0]);
	assign cmdValid = ~|i_cmd[jtagPkg::CMD_W-1:jtagPkg::OP_W];

	always_comb begin
		isAddr   = 1'b0;
		isMem    = 1'b0;
		isAccess = 1'b0;
		isState  = 1'b0;
		case (op)
			jtagPkg::OP_ADDR:   isAddr   = 1'b1;
			jtagPkg::OP_READ,
			jtagPkg::OP_WRITE:  isMem    = 1'b1;
			jtagPkg::OP_SCAN,
			jtagPkg::OP_SPI:    isAccess = 1'b1;
			jtagPkg::OP_RESUME,
			jtagPkg::OP_PAUSE:  isState  = 1'b1;
			default: ;                          // OP_NONE does nothing.
		endcase
	end

	// Act only once per visit to UPDATE, however many clocks it lasts.
	assign inUpdate    = (i_state == jtagPkg::UPDATE);
	assign firstUpdate = inUpdate & ~updDoneQ;

	// Status gates.
	assign exeAddr   = cmdValid & isAddr & firstUpdate;
	assign exeMem    = cmdValid & isMem & firstUpdate & i_isPaused;
	assign exeAccess = cmdValid & isAccess & firstUpdate & i_isPaused;
	assign exeState  = cmdValid & isState & firstUpdate & i_isBooted;

	// ------------------------------
	// Registers
	// ------------------------------

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			updDoneQ <= 1'b0;
			dataQ    <= '0;
			addrQ    <= '0;
			spiSelQ  <= 1'b0;
			scanSelQ <= 1'b0;
			pauseQ   <= 1'b0;
		end else begin
			updDoneQ <= inUpdate; // Clears as soon as UPDATE is left.

			// Data register. A read loads memory, otherwise DSHFT shifts TDI in.
			if (exeMem && (op == jtagPkg::OP_READ)) begin
				dataQ <= i_memDataIn;
			end else if (i_shiftEn) begin
				dataQ <= {dataQ[DATA_W-2:0], i_shiftBit};
			end

			if (exeAddr) begin
				addrQ <= dataQ; // Address comes from the last data shift.
			end

			// Any command rewrites the selects, so only an access command keeps one.
			if (firstUpdate) begin
				spiSelQ  <= exeAccess & (op == jtagPkg::OP_SPI);
				scanSelQ <= exeAccess & (op == jtagPkg::OP_SCAN);
			end

			if (exeState) begin
				pauseQ <= i_cmd[0]; // Pause is 1, resume is 0.
			end
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------

	assign o_memAddr    = addrQ;
	assign o_memDataOut = dataQ;
	assign o_memWr      = i_cmd[0]; // Read and write differ in bit 0.
	assign o_memEn      = exeMem;   // One cycle through firstUpdate.
	assign o_doPause    = pauseQ;
	assign o_dataMsb    = dataQ[DATA_W-1];
	assign o_spiSel     = spiSelQ;
	assign o_scanSel    = scanSelQ;

	// Memory must see a single access per UPDATE.
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		o_memEn |=> !o_memEn);

endmodule

//--- jtagPkg.sv
package jtagPkg;

	// ------------------------------
	// TAP states
	// ------------------------------

	// Simplified six-state TAP in a 3-bit code.
	// Bit 0 marks the two select states.
	typedef enum logic [2:0] {
		IDLE   = 3'b000, // Waits for TMS low.
		ISEL   = 3'b001, // Instruction path chosen.
		ISHFT  = 3'b100, // Command shifting.
		DSEL   = 3'b101, // Data path chosen.
		DSHFT  = 3'b010, // Data shifting.
		UPDATE = 3'b110  // Command acted on here.
	} tapState_e;

	// ------------------------------
	// Commands
	// ------------------------------

	// Low bits of the command register. Upper bits must be zero for a valid command.
	typedef enum logic [2:0] {
		OP_NONE   = 3'b000, // No operation.
		OP_ADDR   = 3'b001, // Load address from data register.
		OP_READ   = 3'b010, // Runtime memory read.
		OP_WRITE  = 3'b011, // Runtime memory write.
		OP_SCAN   = 3'b100, // Select scan chain access.
		OP_SPI    = 3'b101, // Select SPI access.
		OP_RESUME = 3'b110, // Clear pause request.
		OP_PAUSE  = 3'b111  // Set pause request.
	} jtagOp_e;

	localparam int CMD_W = 8; // Command register width.
	localparam int OP_W  = 3; // Opcode field width, at the LSBs.

	// Status bit positions loaded into the command register on ISEL -> ISHFT.
	localparam int STAT_BOOTED = 0;
	localparam int STAT_PAUSED = 1;

endpackage

//--- jtagPort.sv
`timescale 1ns/1ps

module jtagPort #(
	parameter int DATA_W = 16 // Data and address width.
) (
	input  logic              i_clk,
	input  logic              i_rstN,

	// Host pins.
	input  logic              i_TCK,
	input  logic              i_TMS,
	input  logic              i_TDI,
	output logic              o_TDO,

	// Processor status.
	input  logic              i_isBooted,
	input  logic              i_isPaused,

	// Runtime memory.
	input  logic [DATA_W-1:0] i_memDataIn,
	output logic [DATA_W-1:0] o_memAddr,
	output logic [DATA_W-1:0] o_memDataOut,
	output logic              o_memWr,
	output logic              o_memEn,

	// Chain enables and pause request.
	output logic              o_spiAccess,
	output logic              o_scanAccess,
	output logic              o_doPause
);

	// ------------------------------
	// Stage wires
	// ------------------------------

	logic                      tckRise, tckFall;
	logic                      tms, tdi;
	jtagPkg::tapState_e        state;
	logic [jtagPkg::CMD_W-1:0] cmd;
	logic                      shiftBit, shiftEn;
	logic                      dataMsb;
	logic                      spiSel, scanSel;

	// Pin sampling.
	tckSampler u_sampler (
		.i_clk     (i_clk),
		.i_rstN    (i_rstN),
		.i_TCK     (i_TCK),
		.i_TMS     (i_TMS),
		.i_TDI     (i_TDI),
		.o_tckRise (tckRise),
		.o_tckFall (tckFall),
		.o_tms     (tms),
		.o_tdi     (tdi)
	);

	// TAP FSM and command register.
	tapDecode u_decode (
		.i_clk      (i_clk),
		.i_rstN     (i_rstN),
		.i_tckRise  (tckRise),
		.i_tms      (tms),
		.i_tdi      (tdi),
		.i_isBooted (i_isBooted),
		.i_isPaused (i_isPaused),
		.o_state    (state),
		.o_cmd      (cmd),
		.o_shiftBit (shiftBit),
		.o_shiftEn  (shiftEn)
	);

	// Data path and command actions.
	cmdExecute #(
		.DATA_W (DATA_W)
	) u_execute (
		.i_clk        (i_clk),
		.i_rstN       (i_rstN),
		.i_state      (state),
		.i_cmd        (cmd),
		.i_shiftBit   (shiftBit),
		.i_shiftEn    (shiftEn),
		.i_isBooted   (i_isBooted),
		.i_isPaused   (i_isPaused),
		.i_memDataIn  (i_memDataIn),
		.o_memAddr    (o_memAddr),
		.o_memDataOut (o_memDataOut),
		.o_memWr      (o_memWr),
		.o_memEn      (o_memEn),
		.o_doPause    (o_doPause),
		.o_dataMsb    (dataMsb),
		.o_spiSel     (spiSel),
		.o_scanSel    (scanSel)
	);

	// TDO and access enables.
	tdoResult u_result (
		.i_clk        (i_clk),
		.i_rstN       (i_rstN),
		.i_tckFall    (tckFall),
		.i_state      (state),
		.i_cmdMsb     (cmd[jtagPkg::CMD_W-1]),
		.i_dataMsb    (dataMsb),
		.i_spiSel     (spiSel),
		.i_scanSel    (scanSel),
		.o_TDO        (o_TDO),
		.o_spiAccess  (o_spiAccess),
		.o_scanAccess (o_scanAccess)
	);

endmodule

//--- jtag_tests.txt
# step cmd data booted paused expected, all hex; cmd/data steps expect the TDO word
# outs expects bits 4..0 = o_TDO o_scanAccess o_spiAccess o_doPause o_memEn
outs    00 0000 0 0 0000
cmd     00 0000 0 0 0000
data    00 0012 1 1 0000
cmd     01 0000 0 1 0002
data    00 a5c3 1 1 0012
cmd     03 0000 1 1 0003
memcnt  00 0000 1 1 0001
memaddr 00 0000 1 1 0012
memdata 00 0000 1 1 a5c3
memwr   00 0000 1 1 0001
cmd     02 0000 1 1 0003
memcnt  00 0000 1 1 0001
data    00 1111 1 1 a5c3
cmd     03 0000 1 0 0001
cmd     02 0000 1 0 0001
cmd     05 0000 1 0 0001
data    00 2222 1 0 1111
memcnt  00 0000 1 0 0000
spicnt  00 0000 1 0 0000
cmd     07 0000 0 1 0002
pause   00 0000 0 1 0000
cmd     07 0000 1 0 0001
pause   00 0000 1 0 0001
cmd     06 0000 1 0 0001
outs    00 0000 1 0 0000
cmd     05 0000 1 1 0003
data    00 3333 1 1 2222
spicnt  00 0000 1 1 0080
cmd     04 0000 1 1 0003
data    00 4444 1 1 3333
scancnt 00 0000 1 1 0080
spicnt  00 0000 1 1 0000
cmd     00 0000 1 1 0003
data    00 5555 1 1 4444
scancnt 00 0000 1 1 0000

//--- portChecker.sv
`timescale 1ns/1ps

module portChecker (
	input  logic        i_clk,
	input  logic        i_rstN,
	input  logic        i_TDO,
	input  logic        i_memEn,
	input  logic        i_memWr,
	input  logic [15:0] i_memAddr,
	input  logic [15:0] i_memDataOut,
	input  logic        i_spiAccess,
	input  logic        i_scanAccess,
	input  logic        i_doPause,
	input  logic [15:0] i_capVal,    // TDO bits gathered by the sequencer.
	input  logic [15:0] i_expVal,    // Expected value for this check.
	input  logic [3:0]  i_expKind,   // What to compare.
	input  logic        i_expStrobe, // Compare on this cycle.
	output int          o_errCount
);

	localparam logic [3:0] K_OUTS    = 4'd0; // Idle output vector.
	localparam logic [3:0] K_TDO     = 4'd1; // Shifted-out TDO word.
	localparam logic [3:0] K_MEMCNT  = 4'd2; // o_memEn cycles since last count check.
	localparam logic [3:0] K_MEMADDR = 4'd3;
	localparam logic [3:0] K_MEMDATA = 4'd4;
	localparam logic [3:0] K_MEMWR   = 4'd5;
	localparam logic [3:0] K_PAUSE   = 4'd6;
	localparam logic [3:0] K_SPICNT  = 4'd7; // o_spiAccess cycles.
	localparam logic [3:0] K_SCANCNT = 4'd8; // o_scanAccess cycles.

	logic [15:0] memCnt, spiCnt, scanCnt;
	logic [15:0] lastAddr, lastData; // Captured on the last o_memEn cycle.
	logic        lastWr;
	int          errCount = 0;

	task automatic compareValue(input string sigName, input logic [15:0] gotVal,
			input logic [15:0] wantVal);
		if (gotVal !== wantVal) begin
			$display("[FAIL] %s: got %h, expected %h", sigName, gotVal, wantVal);
			errCount++;
		end
	endtask

	// ------------------------------
	// Monitor and compare
	// ------------------------------

	always @(posedge i_clk) begin
		if (!i_rstN) begin
			memCnt   <= '0;
			spiCnt   <= '0;
			scanCnt  <= '0;
			lastAddr <= '0;
			lastData <= '0;
			lastWr   <= 1'b0;
		end else begin
			if (i_memEn) begin
				memCnt   <= memCnt + 1'b1;
				lastAddr <= i_memAddr;    // Bus is only valid with the strobe.
				lastData <= i_memDataOut;
				lastWr   <= i_memWr;
			end
			if (i_spiAccess) spiCnt <= spiCnt + 1'b1;
			if (i_scanAccess) scanCnt <= scanCnt + 1'b1;

			if (i_expStrobe) begin
				case (i_expKind)
					K_OUTS: compareValue("{o_TDO,o_scanAccess,o_spiAccess,o_doPause,o_memEn}",
						{11'd0, i_TDO, i_scanAccess, i_spiAccess, i_doPause, i_memEn}, i_expVal);
					K_TDO:     compareValue("o_TDO bits", i_capVal, i_expVal);
					K_MEMCNT: begin
						compareValue("o_memEn cycles", memCnt, i_expVal);
						memCnt <= '0; // Count restarts per check.
					end
					K_MEMADDR: compareValue("o_memAddr", lastAddr, i_expVal);
					K_MEMDATA: compareValue("o_memDataOut", lastData, i_expVal);
					K_MEMWR:   compareValue("o_memWr", {15'd0, lastWr}, i_expVal);
					K_PAUSE:   compareValue("o_doPause", {15'd0, i_doPause}, i_expVal);
					K_SPICNT: begin
						compareValue("o_spiAccess cycles", spiCnt, i_expVal);
						spiCnt <= '0;
					end
					K_SCANCNT: begin
						compareValue("o_scanAccess cycles", scanCnt, i_expVal);
						scanCnt <= '0;
					end
					default: begin
						$display("Check request with unknown kind %0d", i_expKind);
						errCount++;
					end
				endcase
			end
		end
	end

	assign o_errCount = errCount;

endmodule

//--- tapDecode.sv
`timescale 1ns/1ps

module tapDecode (
	input  logic                         i_clk,
	input  logic                         i_rstN,
	input  logic                         i_tckRise,  // TCK rising strobe.
	input  logic                         i_tms,      // Synchronized TMS.
	input  logic                         i_tdi,      // Synchronized TDI.
	input  logic                         i_isBooted, // Processor status.
	input  logic                         i_isPaused,
	output jtagPkg::tapState_e           o_state,
	output logic [jtagPkg::CMD_W-1:0]    o_cmd,
	output logic                         o_shiftBit, // TDI for the data register.
	output logic                         o_shiftEn   // Data shift strobe.
);

	jtagPkg::tapState_e            stateQ, stateD;
	logic [jtagPkg::CMD_W-1:0]     cmdQ;
	logic [jtagPkg::CMD_W-1:0]     statusWord; // Processor status, LSB aligned.
	logic                          loadStatus; // ISEL -> ISHFT step.
	logic                          inDshft;

	// ------------------------------
	// Next-state logic
	// ------------------------------

	always_comb begin
		stateD = stateQ;
		case (stateQ)
			jtagPkg::IDLE:   stateD = i_tms ? jtagPkg::IDLE : jtagPkg::ISEL;
			jtagPkg::ISEL:   stateD = i_tms ? jtagPkg::DSEL : jtagPkg::ISHFT;
			jtagPkg::ISHFT:  stateD = i_tms ? jtagPkg::UPDATE : jtagPkg::ISHFT;
			jtagPkg::DSEL:   stateD = i_tms ? jtagPkg::IDLE : jtagPkg::DSHFT;
			jtagPkg::DSHFT:  stateD = i_tms ? jtagPkg::IDLE : jtagPkg::DSHFT;
			jtagPkg::UPDATE: stateD = jtagPkg::IDLE; // One TCK in UPDATE only.
			default:         stateD = jtagPkg::IDLE; // Recover from bad codes.
		endcase
	end

	// ------------------------------
	// Status capture
	// ------------------------------

	always_comb begin
		statusWord                       = '0;
		statusWord[jtagPkg::STAT_BOOTED] = i_isBooted;
		statusWord[jtagPkg::STAT_PAUSED] = i_isPaused;
	end

	// Entering instruction shift replaces the shift with a status load.
	assign loadStatus = (stateQ == jtagPkg::ISEL) & ~i_tms;

	// ------------------------------
	// Registers
	// ------------------------------

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			stateQ <= jtagPkg::IDLE;
			cmdQ   <= '0;
		end else if (i_tckRise) begin
			stateQ <= stateD; // Advance once per TCK rise.
			if (loadStatus) begin
				cmdQ <= statusWord;
			end else begin
				cmdQ <= {cmdQ[jtagPkg::CMD_W-2:0], i_tdi}; // TDI in at LSB.
			end
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------

	assign inDshft    = (stateQ == jtagPkg::DSHFT);
	assign o_state    = stateQ;
	assign o_cmd      = cmdQ;
	assign o_shiftBit = i_tdi & inDshft;     // Only meaningful while shifting data.
	assign o_shiftEn  = i_tckRise & inDshft; // Includes the exit edge with TMS high.

	// The state register holds one of the six TAP codes at all times.
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		stateQ inside {jtagPkg::IDLE, jtagPkg::ISEL, jtagPkg::ISHFT,
			jtagPkg::DSEL, jtagPkg::DSHFT, jtagPkg::UPDATE});

endmodule

//--- tb_jtagPort.sv
`timescale 1ns/1ps

module tb_jtagPort;

	localparam int DATA_W      = 16;
	localparam int TCK_HOLD    = 4;  // System clocks per TCK level.
	localparam int QUIET_LIMIT = 40; // Cycles allowed for o_memEn to drop.

	// Check kinds, same coding as portChecker.
	localparam logic [3:0] K_OUTS    = 4'd0;
	localparam logic [3:0] K_TDO     = 4'd1;
	localparam logic [3:0] K_MEMCNT  = 4'd2;
	localparam logic [3:0] K_MEMADDR = 4'd3;
	localparam logic [3:0] K_MEMDATA = 4'd4;
	localparam logic [3:0] K_MEMWR   = 4'd5;
	localparam logic [3:0] K_PAUSE   = 4'd6;
	localparam logic [3:0] K_SPICNT  = 4'd7;
	localparam logic [3:0] K_SCANCNT = 4'd8;

	logic              clk;
	logic              rstN;
	logic              tck, tms, tdi;
	logic              isBooted, isPaused;
	logic [DATA_W-1:0] memDataIn;
	logic              tdo;
	logic [DATA_W-1:0] memAddr, memDataOut;
	logic              memWr, memEn;
	logic              spiAccess, scanAccess, doPause;
	logic [15:0]       mem [0:255]; // Runtime memory model.
	logic [15:0]       capVal, expVal;
	logic [3:0]        expKind;
	logic              expStrobe;
	int                checkErrors;  // From the checker.
	int                otherErrors;  // Timeouts and file problems.
	int                stepCount;
	logic              abortRun;

	always #10 clk = ~clk; // 20 ns period.

	// ------------------------------
	// Memory model
	// ------------------------------

	always @(posedge clk) begin
		if (memEn && memWr) begin
			mem[memAddr[7:0]] <= memDataOut; // Write lands in the strobe cycle.
		end
	end

	assign memDataIn = mem[memAddr[7:0]]; // Combinational read.

	jtagPort #(
		.DATA_W (DATA_W)
	) i_dut (
		.i_clk        (clk),
		.i_rstN       (rstN),
		.i_TCK        (tck),
		.i_TMS        (tms),
		.i_TDI        (tdi),
		.o_TDO        (tdo),
		.i_isBooted   (isBooted),
		.i_isPaused   (isPaused),
		.i_memDataIn  (memDataIn),
		.o_memAddr    (memAddr),
		.o_memDataOut (memDataOut),
		.o_memWr      (memWr),
		.o_memEn      (memEn),
		.o_spiAccess  (spiAccess),
		.o_scanAccess (scanAccess),
		.o_doPause    (doPause)
	);

	portChecker u_checker (
		.i_clk        (clk),
		.i_rstN       (rstN),
		.i_TDO        (tdo),
		.i_memEn      (memEn),
		.i_memWr      (memWr),
		.i_memAddr    (memAddr),
		.i_memDataOut (memDataOut),
		.i_spiAccess  (spiAccess),
		.i_scanAccess (scanAccess),
		.i_doPause    (doPause),
		.i_capVal     (capVal),
		.i_expVal     (expVal),
		.i_expKind    (expKind),
		.i_expStrobe  (expStrobe),
		.o_errCount   (checkErrors)
	);

	// ------------------------------
	// TCK sequencer
	// ------------------------------

	// One TCK period. Called and left on a falling clock edge.
	task automatic tckCycle(input logic tmsBit, input logic tdiBit, output logic tdoBit);
		tck = 1'b0;
		tms = tmsBit;
		tdi = tdiBit;
		repeat (TCK_HOLD) @(negedge clk);
		tdoBit = tdo; // What the host sees at the rise.
		tck    = 1'b1;
		repeat (TCK_HOLD) @(negedge clk);
	endtask

	task automatic shiftCmd(input logic [7:0] cmdVal, output logic [15:0] captured);
		logic bitOut;
		int   i;
		captured = '0;
		tckCycle(1'b0, 1'b0, bitOut); // IDLE to ISEL.
		tckCycle(1'b0, 1'b0, bitOut); // ISEL to ISHFT, status captured.
		for (i = 7; i >= 0; i--) begin
			tckCycle(i == 0, cmdVal[i], bitOut); // MSB first, last bit exits to UPDATE.
			captured = {captured[14:0], bitOut};
		end
		tckCycle(1'b1, 1'b0, bitOut); // UPDATE to IDLE.
	endtask

	task automatic shiftData(input logic [15:0] dataVal, output logic [15:0] captured);
		logic bitOut;
		int   i;
		captured = '0;
		tckCycle(1'b0, 1'b0, bitOut); // IDLE to ISEL.
		tckCycle(1'b1, 1'b0, bitOut); // ISEL to DSEL.
		tckCycle(1'b0, 1'b0, bitOut); // DSEL to DSHFT.
		for (i = 15; i >= 0; i--) begin
			tckCycle(i == 0, dataVal[i], bitOut); // Last bit returns to IDLE.
			captured = {captured[14:0], bitOut};
		end
	endtask

	task automatic runCheck(input logic [3:0] kind, input logic [15:0] want,
			input logic [15:0] got);
		expKind   = kind;
		expVal    = want;
		capVal    = got;
		expStrobe = 1'b1;
		@(negedge clk);
		expStrobe = 1'b0;
	endtask

	// The memory strobe must be gone before the next step starts.
	task automatic waitQuiet();
		int cycles;
		cycles = 0;
		while (memEn && cycles < QUIET_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (memEn) begin
			$display("Timeout: o_memEn still high after %0d cycles", QUIET_LIMIT);
			otherErrors++;
			abortRun = 1'b1;
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial begin
		int                fd;
		int                n;
		int                a;
		logic [8*12-1:0]   opName;
		logic [8*128-1:0]  lineBuf;
		logic [15:0]       cmdIn, dataIn, expIn, capture;
		logic              bootIn, pauseIn;
		logic              fileDone;
		clk         = 1'b0;
		rstN        = 1'b0;
		tck         = 1'b0; // Idle low, so reset release sees no edge.
		tms         = 1'b1;
		tdi         = 1'b0;
		isBooted    = 1'b0;
		isPaused    = 1'b0;
		capVal      = '0;
		expVal      = '0;
		expKind     = K_OUTS;
		expStrobe   = 1'b0;
		otherErrors = 0;
		stepCount   = 0;
		abortRun    = 1'b0;
		for (a = 0; a < 256; a++) begin
			mem[a] = {a[7:0] ^ 8'h5a, a[7:0]};
		end
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		repeat (2) @(negedge clk); // Let the synchronizers settle.

		fd       = $fopen("jtag_tests.txt", "r");
		fileDone = (fd == 0);
		if (fd == 0) begin
			$display("Could not open jtag_tests.txt");
			otherErrors++;
		end
		while (!fileDone && !abortRun) begin
			n = $fscanf(fd, "%s", opName);
			if (n != 1) begin
				fileDone = 1'b1; // End of file.
			end else if (opName == "#") begin
				n = $fgets(lineBuf, fd); // Rest of a comment line.
			end else if ($fscanf(fd, "%h %h %h %h %h", cmdIn, dataIn, bootIn, pauseIn,
					expIn) != 5) begin
				$display("Malformed line in jtag_tests.txt after step %0d", stepCount);
				otherErrors++;
				fileDone = 1'b1;
			end else begin
				stepCount++;
				waitQuiet();
				isBooted = bootIn;
				isPaused = pauseIn;
				capture  = '0;
				if (!abortRun) begin
					case (opName)
						"outs": runCheck(K_OUTS, expIn, capture);
						"cmd": begin
							shiftCmd(cmdIn[7:0], capture);
							runCheck(K_TDO, expIn, capture); // Status word.
						end
						"data": begin
							shiftData(dataIn, capture);
							runCheck(K_TDO, expIn, capture); // Previous data register.
						end
						"memcnt":  runCheck(K_MEMCNT, expIn, capture);
						"memaddr": runCheck(K_MEMADDR, expIn, capture);
						"memdata": runCheck(K_MEMDATA, expIn, capture);
						"memwr":   runCheck(K_MEMWR, expIn, capture);
						"pause":   runCheck(K_PAUSE, expIn, capture);
						"spicnt":  runCheck(K_SPICNT, expIn, capture);
						"scancnt": runCheck(K_SCANCNT, expIn, capture);
						default: begin
							$display("Unknown step name at step %0d", stepCount);
							otherErrors++;
						end
					endcase
				end
			end
		end
		if (fd != 0) $fclose(fd);

		$display("Steps run: %0d  value errors: %0d  other errors: %0d",
			stepCount, checkErrors, otherErrors);
		if (checkErrors == 0 && otherErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- tckSampler.sv
`timescale 1ns/1ps

module tckSampler (
	input  logic i_clk,
	input  logic i_rstN,
	input  logic i_TCK,     // Raw host pins, asynchronous to i_clk.
	input  logic i_TMS,
	input  logic i_TDI,
	output logic o_tckRise, // One-cycle strobe per TCK rising edge.
	output logic o_tckFall, // One-cycle strobe per TCK falling edge.
	output logic o_tms,     // Synchronized TMS level.
	output logic o_tdi      // Synchronized TDI level.
);

	// ------------------------------
	// Synchronizers
	// ------------------------------

	logic [1:0] tckSync; // Bit 0 is the first stage.
	logic [1:0] tmsSync;
	logic [1:0] tdiSync;
	logic       tckPrev; // Synchronized TCK one cycle back.

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			tckSync <= '0;
			tmsSync <= '0;
			tdiSync <= '0;
			tckPrev <= 1'b0;
		end else begin
			tckSync <= {tckSync[0], i_TCK}; // Two flops per pin.
			tmsSync <= {tmsSync[0], i_TMS};
			tdiSync <= {tdiSync[0], i_TDI};
			tckPrev <= tckSync[1];          // Edge history.
		end
	end

	// ------------------------------
	// Edge strobes
	// ------------------------------

	// TMS and TDI go through the same depth as TCK, so they line up with the strobes.
	assign o_tckRise = tckSync[1] & ~tckPrev;
	assign o_tckFall = ~tckSync[1] & tckPrev;
	assign o_tms     = tmsSync[1];
	assign o_tdi     = tdiSync[1];

	// A single synchronized TCK cannot rise and fall in one cycle.
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		!(o_tckRise && o_tckFall));

endmodule

//--- tdoResult.sv
`timescale 1ns/1ps

module tdoResult (
	input  logic               i_clk,
	input  logic               i_rstN,
	input  logic               i_tckFall, // TCK falling strobe.
	input  jtagPkg::tapState_e i_state,
	input  logic               i_cmdMsb,  // Command register MSB.
	input  logic               i_dataMsb, // Data register MSB.
	input  logic               i_spiSel,
	input  logic               i_scanSel,
	output logic               o_TDO,
	output logic               o_spiAccess,
	output logic               o_scanAccess
);

	logic inDshft;
	logic tdoQ;

	assign inDshft = (i_state == jtagPkg::DSHFT);

	// ------------------------------
	// TDO flop
	// ------------------------------

	// Updated on the fall so the bit is stable by the next TCK rise.
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			tdoQ <= 1'b0;
		end else if (i_tckFall) begin
			tdoQ <= inDshft ? i_dataMsb : i_cmdMsb; // Data path only in DSHFT.
		end
	end

	assign o_TDO = tdoQ;

	// ------------------------------
	// Access enables
	// ------------------------------

	assign o_spiAccess  = i_spiSel & inDshft;  // Live during data shift only.
	assign o_scanAccess = i_scanSel & inDshft;

	// The two selects come from one command, so at most one chain is open.
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		!(o_spiAccess && o_scanAccess));

endmodule
